/* common/img_pkg.sv */
/*
  Image loopback store shared types
  Pixel word views, display color, UART byte and transmit request
  records, plus default sizing used by the top level
*/

package img_pkg;

  // One stored pixel byte
  typedef logic [7:0] pixel_t;

  // RGB 3-3-2 color view of a stored byte
  typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
  } rgb332_t;

  // Same stored word read as grey or as color
  typedef union packed {
    pixel_t  grey;
    rgb332_t color;
  } pixel_u;

  // Expanded display color
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef struct packed {
    logic   strobe;
    pixel_t data;
  } rx_byte_t;

  typedef struct packed {
    logic   load;
    pixel_t data;
  } tx_req_t;

  // 115200 baud from a 50 MHz clock
  localparam logic [15:0] DEF_CLKS_PER_BIT = 16'd434;
  localparam int DEF_IMG_PIXELS = 64;
  localparam int DEF_NUM_IMAGES = 4;

endpackage

/* logic/uart_rx.sv */
/*
  UART receiver, 8N1
  Synchronizes the serial line, finds the start bit, samples each
  bit at its center and strobes out bytes with a valid stop bit
*/

module uart_rx #(
  parameter logic [15:0] clks_per_bit = img_pkg::DEF_CLKS_PER_BIT
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  logic              rxd,
  output img_pkg::rx_byte_t rx_byte
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_start = 2'd1;
  localparam logic [1:0] st_data  = 2'd2;
  localparam logic [1:0] st_stop  = 2'd3;
  localparam logic [15:0] half_bit = clks_per_bit >> 1;

  logic            rxd_meta;
  logic            rxd_sync;
  logic [1:0]      state;
  logic [15:0]     bit_cnt;
  logic [2:0]      bit_idx;
  logic            bit_end;
  logic            strobe_q;
  img_pkg::pixel_t shift_q;
  img_pkg::pixel_t data_q;

  assign bit_end = (bit_cnt == clks_per_bit - 16'd1);
  assign rx_byte = '{strobe: strobe_q, data: data_q};

  // ==========================================================================
  // Line sync and bit timing
  // ==========================================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      state    <= st_idle;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      strobe_q <= 1'b0;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      strobe_q <= 1'b0;
      case (state)
        st_idle: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          if (!rxd_sync) begin
            state <= st_start;
          end
        end
        st_start: begin
          // Recheck the line half a bit in so glitches go back to idle
          if (bit_cnt == half_bit - 16'd1) begin
            bit_cnt <= '0;
            state   <= rxd_sync ? st_idle : st_data;
          end else begin
            bit_cnt <= bit_cnt + 16'd1;
          end
        end
        st_data: begin
          if (bit_end) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end else begin
            bit_cnt <= bit_cnt + 16'd1;
          end
        end
        default: begin
          // A low stop bit drops the byte
          if (bit_end) begin
            strobe_q <= rxd_sync;
            state    <= st_idle;
          end else begin
            bit_cnt <= bit_cnt + 16'd1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge CLOCK_50) begin
    if (state == st_data && bit_end) begin
      shift_q <= {rxd_sync, shift_q[7:1]};
    end
    if (state == st_stop && bit_end) begin
      data_q <= shift_q;
    end
  end

endmodule

/* logic/uart_tx.sv */
/*
  UART transmitter, 8N1
  Frames one byte with start and stop bits and pulses done
  once the stop bit has fully gone out
*/

module uart_tx #(
  parameter logic [15:0] clks_per_bit = img_pkg::DEF_CLKS_PER_BIT
) (
  input  logic             CLOCK_50,
  input  logic             DLY_RST_0,
  input  img_pkg::tx_req_t tx_req,
  output logic             txd,
  output logic             tx_done
);

  logic        busy;
  logic [15:0] bit_cnt;
  logic [3:0]  bit_idx;
  logic        bit_end;
  logic [8:0]  frame_q;

  assign bit_end = busy && (bit_cnt == clks_per_bit - 16'd1);

  // Bit index 0 is the start bit, 9 the stop bit
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (!busy) begin
        if (tx_req.load) begin
          busy    <= 1'b1;
          bit_cnt <= '0;
          bit_idx <= '0;
          txd     <= 1'b0;
        end
      end else if (bit_end) begin
        bit_cnt <= '0;
        if (bit_idx == 4'd9) begin
          busy    <= 1'b0;
          tx_done <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 4'd1;
          txd     <= frame_q[0];
        end
      end else begin
        bit_cnt <= bit_cnt + 16'd1;
      end
    end
  end

  // Data bits and the stop bit shift out with ones filling from the top
  always_ff @(posedge CLOCK_50) begin
    if (!busy && tx_req.load) begin
      frame_q <= {1'b1, tx_req.data};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[8:1]};
    end
  end

endmodule

/* frame_store/frame_store.sv */
/*
  Frame store
  On-chip buffer of several images, filled in sequence from the
  receiver, with an image select register and two read ports
  relative to the current image
*/

module frame_store #(
  parameter  int img_pixels = img_pkg::DEF_IMG_PIXELS,
  parameter  int num_images = img_pkg::DEF_NUM_IMAGES,
  localparam int pix_w      = $clog2(img_pixels),
  localparam int img_w      = $clog2(num_images)
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  img_pkg::rx_byte_t rx_byte,
  input  logic              load_mode,
  input  logic [pix_w-1:0]  tx_index,
  output img_pkg::pixel_t   tx_pixel,
  input  logic [pix_w-1:0]  pix_addr,
  output img_pkg::pixel_u   pix_word,
  output logic [img_w-1:0]  cur_img
);

  localparam int total  = num_images * img_pixels;
  localparam int addr_w = $clog2(total);

  img_pkg::pixel_t   mem [total];
  logic [addr_w-1:0] load_ptr;
  logic [addr_w-1:0] img_base;
  logic [addr_w-1:0] tx_addr;
  logic [addr_w-1:0] pix_rd_addr;
  logic              load_wr;
  logic              img_sel;

  // Received bytes either fill the buffer or pick the image
  assign load_wr = rx_byte.strobe && load_mode;
  assign img_sel = rx_byte.strobe && !load_mode;

  // Start of the current image in the buffer
  assign img_base    = addr_w'(cur_img * img_pixels);
  assign tx_addr     = img_base + addr_w'(tx_index);
  assign pix_rd_addr = img_base + addr_w'(pix_addr);

  // ==========================================================================
  // Load pointer and image select
  // ==========================================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      load_ptr <= '0;
      cur_img  <= '0;
    end else begin
      if (load_wr) begin
        if (load_ptr == addr_w'(total - 1)) begin
          load_ptr <= '0;
        end else begin
          load_ptr <= load_ptr + 1'b1;
        end
      end
      // Image count is a power of two, low bits give the modulo
      if (img_sel) begin
        cur_img <= rx_byte.data[img_w-1:0];
      end
    end
  end

  // ==========================================================================
  // Buffer write and both read ports
  // ==========================================================================
  always_ff @(posedge CLOCK_50) begin
    if (load_wr) begin
      mem[load_ptr] <= rx_byte.data;
    end
    tx_pixel      <= mem[tx_addr];
    pix_word.grey <= mem[pix_rd_addr];
  end

endmodule

/* logic/tx_sequencer.sv */
/*
  Transmit sequencer
  Walks the current image byte by byte on a start key, handing
  each byte to the UART transmitter and waiting for its done
*/

module tx_sequencer #(
  parameter  int img_pixels = img_pkg::DEF_IMG_PIXELS,
  localparam int pix_w      = $clog2(img_pixels)
) (
  input  logic             CLOCK_50,
  input  logic             DLY_RST_0,
  input  logic             tx_start_n,
  input  logic             tx_stop_n,
  input  logic             tx_done,
  input  img_pkg::pixel_t  tx_pixel,
  output logic [pix_w-1:0] tx_index,
  output img_pkg::tx_req_t tx_req,
  output logic             tx_active
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_read = 2'd1;
  localparam logic [1:0] st_load = 2'd2;
  localparam logic [1:0] st_wait = 2'd3;

  logic [1:0] state;
  logic       frame_out;
  logic       last_byte;

  assign last_byte = (tx_index == pix_w'(img_pixels - 1));
  assign tx_active = (state != st_idle);

  // Read data arrives one cycle after st_read, in time for the load
  assign tx_req = '{load: (state == st_load), data: tx_pixel};

  // ==========================================================================
  // Transfer FSM
  // ==========================================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state     <= st_idle;
      tx_index  <= '0;
      frame_out <= 1'b0;
    end else begin
      // A frame left over from an abort must finish before the next load
      if (state == st_load) begin
        frame_out <= 1'b1;
      end else if (tx_done) begin
        frame_out <= 1'b0;
      end

      if (!tx_stop_n) begin
        state <= st_idle;
      end else begin
        case (state)
          st_idle: begin
            if (!tx_start_n) begin
              tx_index <= '0;
              state    <= st_read;
            end
          end
          st_read: begin
            if (!frame_out) begin
              state <= st_load;
            end
          end
          st_load: state <= st_wait;
          default: begin
            if (tx_done) begin
              if (last_byte) begin
                state <= st_idle;
              end else begin
                tx_index <= tx_index + 1'b1;
                state    <= st_read;
              end
            end
          end
        endcase
      end
    end
  end

endmodule

/* logic/pixel_decode.sv */
/*
  Display pixel decoder
  Expands a stored byte to 8-bit red, green and blue, as grey
  or as RGB 3-3-2, and registers the result
*/

module pixel_decode (
  input  logic            CLOCK_50,
  input  logic            DLY_RST_0,
  input  img_pkg::pixel_u pix_word,
  input  logic            grey_mode,
  output img_pkg::rgb_t   pix_rgb
);

  img_pkg::rgb_t rgb_next;

  always_comb begin
    if (grey_mode) begin
      rgb_next.red   = pix_word.grey;
      rgb_next.green = pix_word.grey;
      rgb_next.blue  = pix_word.grey;
    end else begin
      // Fields sit at the top of each color, zeros below
      rgb_next.red   = {pix_word.color.red, 5'b00000};
      rgb_next.green = {pix_word.color.green, 5'b00000};
      rgb_next.blue  = {pix_word.color.blue, 6'b000000};
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      pix_rgb <= '0;
    end else begin
      pix_rgb <= rgb_next;
    end
  end

endmodule

/* logic/image_loop_top.sv */
/*
  Serial image loopback store
  UART bytes load a multi-image buffer or select an image, the
  current image can be sent back out and read for display
*/

module image_loop_top #(
  parameter  logic [15:0] clks_per_bit = img_pkg::DEF_CLKS_PER_BIT,
  parameter  int          img_pixels   = img_pkg::DEF_IMG_PIXELS,
  parameter  int          num_images   = img_pkg::DEF_NUM_IMAGES,
  localparam int          pix_w        = $clog2(img_pixels),
  localparam int          img_w        = $clog2(num_images)
) (
  input  logic             CLOCK_50,
  input  logic             DLY_RST_0,
  input  logic             uart_rxd,
  input  logic             load_mode,
  input  logic             grey_mode,
  input  logic             tx_start_n,
  input  logic             tx_stop_n,
  input  logic [pix_w-1:0] pix_addr,
  output logic             uart_txd,
  output img_pkg::rgb_t    pix_rgb,
  output logic [img_w-1:0] cur_img,
  output logic             tx_active
);

  img_pkg::rx_byte_t rx_byte;
  img_pkg::pixel_t   tx_pixel;
  img_pkg::pixel_u   pix_word;
  img_pkg::tx_req_t  tx_req;
  logic [pix_w-1:0]  tx_index;
  logic              tx_done;

  // ==========================================================================
  // Receive and store
  // ==========================================================================
  uart_rx #(.clks_per_bit(clks_per_bit)) rx_i (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rxd       (uart_rxd),
    .rx_byte   (rx_byte)
  );

  frame_store #(.img_pixels(img_pixels), .num_images(num_images)) store_i (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rx_byte   (rx_byte),
    .load_mode (load_mode),
    .tx_index  (tx_index),
    .tx_pixel  (tx_pixel),
    .pix_addr  (pix_addr),
    .pix_word  (pix_word),
    .cur_img   (cur_img)
  );

  // ==========================================================================
  // Transmit path and display
  // ==========================================================================
  tx_sequencer #(.img_pixels(img_pixels)) seq_i (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .tx_start_n (tx_start_n),
    .tx_stop_n  (tx_stop_n),
    .tx_done    (tx_done),
    .tx_pixel   (tx_pixel),
    .tx_index   (tx_index),
    .tx_req     (tx_req),
    .tx_active  (tx_active)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) tx_i (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx_req    (tx_req),
    .txd       (uart_txd),
    .tx_done   (tx_done)
  );

  pixel_decode decode_i (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .pix_word  (pix_word),
    .grey_mode (grey_mode),
    .pix_rgb   (pix_rgb)
  );

endmodule

/* bench/tb_image_loop.sv */
/*
  Testbench for the serial image loopback store
  Loads LFSR pixel data over the UART, then checks image select,
  both display decodes and the transmit path against a buffer model
*/

module tb_image_loop;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [15:0] clks_per_bit = 16'd8;
  localparam int img_pixels   = 16;
  localparam int num_images   = 4;
  localparam int total_pixels = img_pixels * num_images;
  localparam int pix_w        = $clog2(img_pixels);
  localparam int num_tests    = 19;
  localparam int byte_wait    = 30 * int'(clks_per_bit);
  localparam int op_reset     = 0;
  localparam int op_load      = 1;
  localparam int op_select    = 2;
  localparam int op_display   = 3;
  localparam int op_transmit  = 4;
  localparam int op_abort     = 5;

  logic             CLOCK_50;
  logic             DLY_RST_0;
  logic             uart_rxd;
  logic             load_mode;
  logic             grey_mode;
  logic             tx_start_n;
  logic             tx_stop_n;
  logic [pix_w-1:0] pix_addr;
  logic             uart_txd;
  img_pkg::rgb_t    pix_rgb;
  logic [1:0]       cur_img;
  logic             tx_active;

  string       test_name [num_tests];
  int          test_op   [num_tests];
  int          test_data [num_tests];
  int          test_exp  [num_tests];
  logic [7:0]  model_mem [total_pixels];
  logic [31:0] lfsr_state;
  int          test_cnt;
  int          model_img;
  int          model_ptr;
  int          test_err;
  int          error_count;
  int          pass_count;
  int          fail_count;
  int          cycle_cnt;
  int          cycle_limit;

  image_loop_top #(
    .clks_per_bit(clks_per_bit), .img_pixels(img_pixels), .num_images(num_images)
  ) dut_i (
    .CLOCK_50(CLOCK_50), .DLY_RST_0(DLY_RST_0), .uart_rxd(uart_rxd),
    .load_mode(load_mode), .grey_mode(grey_mode), .tx_start_n(tx_start_n),
    .tx_stop_n(tx_stop_n), .pix_addr(pix_addr), .uart_txd(uart_txd),
    .pix_rgb(pix_rgb), .cur_img(cur_img), .tx_active(tx_active)
  );

  always #2 CLOCK_50 = ~CLOCK_50;

  // Watchdog over the whole run
  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLOCK_50);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
    $display("Finished with errors");
    $finish;
  end

  // ==========================================================================
  // Stimulus sources and checks
  // ==========================================================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_byte(output logic [7:0] b);
    int i;
    for (i = 0; i < 8; i++) begin
      b[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Grey copies the byte and color puts each field at the top of its color
  function automatic logic [23:0] expand_pixel(input logic [7:0] p, input logic grey);
    if (grey) begin
      return {p, p, p};
    end
    return {p[7:5], 5'b0, p[4:2], 5'b0, p[1:0], 6'b0};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %0h actual %0h", what, expected, actual);
      test_err++;
    end
  endtask

  task automatic note_failure(input string what, input string msg);
    $display("Error in %s, %s", what, msg);
    test_err++;
  endtask

  task automatic add_test(input string name, input int op, input int data, input int exp);
    test_name[test_cnt] = name;
    test_op[test_cnt]   = op;
    test_data[test_cnt] = data;
    test_exp[test_cnt]  = exp;
    test_cnt++;
  endtask

  // 8N1 frame on the receive line plus an idle gap for the store update
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int i;
    frame = {1'b1, b, 1'b0};
    @(posedge CLOCK_50);
    for (i = 0; i < 10; i++) begin
      uart_rxd <= frame[i];
      repeat (clks_per_bit) @(posedge CLOCK_50);
    end
    repeat (2) @(posedge CLOCK_50);
  endtask

  // Samples uart_txd at bit centers after the start edge
  task automatic recv_byte(input int wait_limit, output logic [7:0] b,
                           output bit got, output bit framed);
    int n;
    int i;
    n = 0;
    got = 1'b0;
    framed = 1'b1;
    b = '0;
    @(posedge CLOCK_50);
    while (uart_txd !== 1'b0 && n < wait_limit) begin
      @(posedge CLOCK_50);
      n++;
    end
    if (uart_txd === 1'b0) begin
      got = 1'b1;
      repeat (clks_per_bit / 2 - 1) @(posedge CLOCK_50);
      framed = (uart_txd === 1'b0);
      for (i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(posedge CLOCK_50);
        b[i] = uart_txd;
      end
      repeat (clks_per_bit) @(posedge CLOCK_50);
      framed = framed && (uart_txd === 1'b1);
    end
  endtask

  task automatic press_key(input bit stop_key);
    @(posedge CLOCK_50);
    if (stop_key) tx_stop_n <= 1'b0;
    else tx_start_n <= 1'b0;
    @(posedge CLOCK_50);
    tx_stop_n  <= 1'b1;
    tx_start_n <= 1'b1;
    @(posedge CLOCK_50);
  endtask

  // Receives count bytes of the current image and checks each one
  task automatic expect_bytes(input string what, input int count, output int received);
    logic [7:0] b;
    bit got;
    bit framed;
    int k;
    received = 0;
    for (k = 0; k < count; k++) begin
      recv_byte(byte_wait, b, got, framed);
      if (!got) begin
        note_failure(what, "no byte arrived on uart_txd");
        break;
      end
      if (!framed) note_failure(what, "bad start or stop bit on uart_txd");
      check_value(what, model_mem[model_img * img_pixels + k], b);
      received++;
    end
  endtask

  // ==========================================================================
  // Table entries
  // ==========================================================================
  task automatic run_test(input int t);
    string      name;
    logic [7:0] b;
    logic       grey;
    bit         got;
    bit         framed;
    int         n;
    name = test_name[t];
    case (test_op[t])
      op_reset: begin
        check_value(name, 0, tx_active);
        check_value(name, 1, uart_txd);
        check_value(name, test_exp[t], cur_img);
      end
      op_load: begin
        @(posedge CLOCK_50);
        load_mode <= 1'b1;
        for (n = 0; n < test_data[t]; n++) begin
          take_byte(b);
          model_mem[model_ptr] = b;
          model_ptr = (model_ptr + 1) % total_pixels;
          send_byte(b);
        end
        load_mode <= 1'b0;
        check_value(name, test_exp[t], cur_img);
      end
      op_select: begin
        @(posedge CLOCK_50);
        load_mode <= 1'b0;
        send_byte(test_data[t][7:0]);
        model_img = test_data[t] % num_images;
        check_value(name, test_exp[t], cur_img);
      end
      op_display: begin
        grey = (test_data[t] != 0);
        check_value(name, test_exp[t], cur_img);
        @(posedge CLOCK_50);
        grey_mode <= grey;
        // One new address per cycle with each result checked 2 cycles later
        for (n = 0; n < img_pixels + 2; n++) begin
          @(posedge CLOCK_50);
          if (n < img_pixels) pix_addr <= pix_w'(n);
          @(negedge CLOCK_50);
          if (n >= 2) begin
            b = model_mem[model_img * img_pixels + n - 2];
            check_value(name, expand_pixel(b, grey), pix_rgb);
          end
        end
      end
      op_transmit: begin
        press_key(1'b0);
        check_value(name, 1, tx_active);
        expect_bytes(name, test_data[t], n);
        check_value(name, test_exp[t], n);
        recv_byte(4 * int'(clks_per_bit), b, got, framed);
        if (got) note_failure(name, "an extra byte followed the image");
        check_value(name, 0, tx_active);
        check_value(name, 1, uart_txd);
      end
      op_abort: begin
        press_key(1'b0);
        expect_bytes(name, test_data[t], n);
        fork
          recv_byte(byte_wait, b, got, framed);
          begin
            repeat (2 * clks_per_bit) @(posedge CLOCK_50);
            press_key(1'b1);
            check_value(name, 0, tx_active);
          end
        join
        n = 0;
        if (got) begin
          n++;
          if (!framed) note_failure(name, "bad start or stop bit on uart_txd");
          check_value(name, model_mem[model_img * img_pixels + test_data[t]], b);
        end
        recv_byte(byte_wait, b, got, framed);
        if (got) n++;
        if (n > test_exp[t]) note_failure(name, "uart_txd kept sending after the stop key");
        check_value(name, 0, tx_active);
        check_value(name, 1, uart_txd);
      end
      default: note_failure(name, "unknown table operation");
    endcase
  endtask

  initial begin
    int t;
    int table_bytes;
    CLOCK_50   = 1'b0;
    DLY_RST_0  = 1'b0;
    uart_rxd   = 1'b1;
    load_mode  = 1'b0;
    grey_mode  = 1'b0;
    tx_start_n = 1'b1;
    tx_stop_n  = 1'b1;
    pix_addr   = '0;
    lfsr_state = 32'he459f960;
    test_cnt = 0;
    model_img = 0;
    model_ptr = 0;
    error_count = 0;
    pass_count = 0;
    fail_count = 0;
    add_test("reset_state", op_reset, 0, 0);
    add_test("load_images", op_load, total_pixels, 0);
    add_test("select_img0", op_select, 8'h04, 0);
    add_test("grey_img0", op_display, 1, 0);
    add_test("color_img0", op_display, 0, 0);
    add_test("select_img1", op_select, 8'h0d, 1);
    add_test("grey_img1", op_display, 1, 1);
    add_test("color_img1", op_display, 0, 1);
    add_test("select_img2", op_select, 8'h7e, 2);
    add_test("grey_img2", op_display, 1, 2);
    add_test("color_img2", op_display, 0, 2);
    add_test("select_img3", op_select, 8'hff, 3);
    add_test("grey_img3", op_display, 1, 3);
    add_test("color_img3", op_display, 0, 3);
    add_test("transmit_img3", op_transmit, img_pixels, img_pixels);
    add_test("reselect_img1", op_select, 8'h21, 1);
    add_test("transmit_img1", op_transmit, img_pixels, img_pixels);
    add_test("abort_img1", op_abort, 2, 1);
    add_test("transmit_after_abort", op_transmit, img_pixels, img_pixels);
    table_bytes = 0;
    for (t = 0; t < test_cnt; t++) begin
      if (test_op[t] == op_load || test_op[t] == op_transmit) table_bytes += test_data[t];
      if (test_op[t] == op_select) table_bytes += 1;
      if (test_op[t] == op_abort) table_bytes += test_data[t] + 2;
    end
    cycle_limit = table_bytes * 10 * int'(clks_per_bit) * 2 + 2000;

    repeat (4) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;
    @(posedge CLOCK_50);
    for (t = 0; t < test_cnt; t++) begin
      test_err = 0;
      run_test(t);
      error_count += test_err;
      if (test_err == 0) begin
        pass_count++;
        $display("Test %s passed", test_name[t]);
      end else begin
        fail_count++;
        $display("Test %s failed with %0d errors", test_name[t], test_err);
      end
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* flist.f */
common/img_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
frame_store/frame_store.sv
logic/tx_sequencer.sv
logic/pixel_decode.sv
logic/image_loop_top.sv
bench/tb_image_loop.sv
